//--- mem_system.f
verilog/mem_system_pkg.sv
verilog/cache_array.sv
verilog/cache.sv
verilog/four_bank_mem.sv
verilog/cache_cntrl.sv
verilog/mem_system.sv
testbench/mem_system_assertions.sv
testbench/mem_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mem_system_tb \
   -f mem_system.f -o mem_system_sim &&
./obj_dir/mem_system_sim || {
   echo "simulation did not complete successfully"
   exit 1
}

//--- testbench/mem_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system_tb;

   import mem_system_pkg::*;

   localparam int PERIOD = 100;
   localparam int RESET_CYCLES = 3;
   localparam int NUM_ENTRIES = 14;
   localparam int NUM_RANDOM = 200;
   localparam int CYCLES_PER_OP = 40;
   localparam int TIMEOUT_NS =
      (RESET_CYCLES + (NUM_ENTRIES + NUM_RANDOM) * CYCLES_PER_OP) * PERIOD;

   typedef enum logic [1:0] {
      op_rd,
      op_wr,
      op_both
   } op_t;

   typedef struct {
      string name;
      op_t   op;
      addr_t addr;
      word_t data;
      logic  exp_hit;
      logic  exp_err;
   } stim_t;

   logic        clk = 1'b0;
   logic        reset;
   addr_t       addr;
   word_t       data_in;
   logic        rd;
   logic        wr;
   word_t       data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;
   stim_t       stim [NUM_ENTRIES];
   word_t       model_mem [MEM_WORDS];
   tag_t        model_tag [LINES];
   logic        model_valid [LINES];
   word_t       last_read;
   logic        have_read;
   int unsigned seed_result;

   mem_system UUT (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #(PERIOD / 2) clk = ~clk;

   // Byte address from tag, line index and word select
   function automatic addr_t make_addr(input int tag, input int index, input int sel);
      return addr_t'((tag << (INDEX_W + SEL_W + 1)) | (index << (SEL_W + 1)) | (sel << 1));
   endfunction

   function automatic logic predict_hit(input addr_t a);
      index_t idx;
      idx = a[10:3];
      return model_valid[idx] && (model_tag[idx] == a[15:11]);
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
         $display("Test FAILED");
         $fatal(1, "check failed");
      end
   endtask

   task automatic run_op(input string name, input op_t op, input addr_t a, input word_t d,
                         input logic exp_hit, input logic exp_err);
      int     cycles;
      index_t idx;
      @(negedge clk);
      check({name, " idle stall"}, 32'd0, 32'(stall));
      addr = a;
      data_in = d;
      rd = (op != op_wr);
      wr = (op != op_rd);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         check({name, " busy stall"}, 32'd1, 32'(stall));
         if (cycles == 1) begin
            // Request is only held in the strobe cycle
            rd = 1'b0;
            wr = 1'b0;
            addr = ~a;
            data_in = ~d;
         end
      end while (!done);
      check({name, " hit"}, 32'(exp_hit), 32'(cache_hit));
      check({name, " err"}, 32'(exp_err), 32'(err));
      if (exp_hit) begin
         check({name, " hit latency"}, 32'd1, 32'(cycles));
      end
      if (!exp_err) begin
         idx = a[10:3];
         model_valid[idx] = 1'b1;
         model_tag[idx] = a[15:11];
      end
      if (op == op_rd && !exp_err) begin
         check({name, " data"}, 32'(model_mem[a[15:1]]), 32'(data_out));
         last_read = model_mem[a[15:1]];
         have_read = 1'b1;
      end else begin
         if (!exp_err) begin
            model_mem[a[15:1]] = d;
         end
         if (have_read) begin
            check({name, " held data"}, 32'(last_read), 32'(data_out));
         end
      end
   endtask

   task automatic run_random(input int count);
      addr_t a;
      word_t d;
      op_t   op;
      for (int i = 0; i < count; i++) begin
         a = make_addr(int'($urandom % 4), int'($urandom % 3), int'($urandom % 4));
         d = word_t'($urandom);
         op = ($urandom % 2 == 0) ? op_rd : op_wr;
         run_op($sformatf("random %0d", i), op, a, d, predict_hit(a), 1'b0);
      end
   endtask

   initial begin
      seed_result = $urandom(32'hf17c3e6e);
      reset = 1'b1;
      addr = '0;
      data_in = '0;
      rd = 1'b0;
      wr = 1'b0;
      have_read = 1'b0;
      last_read = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < LINES; i++) begin
         model_valid[i] = 1'b0;
         model_tag[i] = '0;
      end

      // Line 3 is shared by tags 1 and 5 to force writebacks
      stim[0] = '{"write first", op_wr, make_addr(1, 3, 0), 16'h1234, 1'b0, 1'b0};
      stim[1] = '{"read back", op_rd, make_addr(1, 3, 0), 16'h0000, 1'b1, 1'b0};
      stim[2] = '{"read filled word", op_rd, make_addr(1, 3, 2), 16'h0000, 1'b1, 1'b0};
      stim[3] = '{"write hit", op_wr, make_addr(1, 3, 1), 16'hbeef, 1'b1, 1'b0};
      stim[4] = '{"read untouched", op_rd, make_addr(2, 7, 0), 16'h0000, 1'b0, 1'b0};
      stim[5] = '{"write evicts dirty", op_wr, make_addr(5, 3, 3), 16'h5a5a, 1'b0, 1'b0};
      stim[6] = '{"read written back", op_rd, make_addr(1, 3, 0), 16'h0000, 1'b0, 1'b0};
      stim[7] = '{"read neighbour", op_rd, make_addr(1, 3, 1), 16'h0000, 1'b1, 1'b0};
      stim[8] = '{"read clean evict", op_rd, make_addr(5, 3, 3), 16'h0000, 1'b0, 1'b0};
      stim[9] = '{"odd address", op_rd, make_addr(5, 3, 3) + 16'd1, 16'h0000, 1'b0, 1'b1};
      stim[10] = '{"rd and wr", op_both, make_addr(5, 3, 3), 16'hffff, 1'b0, 1'b1};
      stim[11] = '{"read after errors", op_rd, make_addr(5, 3, 3), 16'h0000, 1'b1, 1'b0};
      stim[12] = '{"write line zero", op_wr, make_addr(0, 0, 0), 16'h0001, 1'b0, 1'b0};
      stim[13] = '{"read line zero", op_rd, make_addr(0, 0, 2), 16'h0000, 1'b1, 1'b0};

      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      check("reset stall", 32'd0, 32'(stall));
      check("reset done", 32'd0, 32'(done));
      check("reset err", 32'd0, 32'(err));
      check("reset hit", 32'd0, 32'(cache_hit));

      for (int i = 0; i < NUM_ENTRIES; i++) begin
         run_op(stim[i].name, stim[i].op, stim[i].addr, stim[i].data,
                stim[i].exp_hit, stim[i].exp_err);
      end
      run_random(NUM_RANDOM);

      $display("Test OK");
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the memory system stopped answering requests");
      $display("Test FAILED");
      $fatal(1, "simulation hung");
   end

endmodule

`default_nettype wire

//--- testbench/mem_system_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system_assertions (
   input logic clk,
   input logic reset,
   input logic done,
   input logic stall,
   input logic err,
   input logic mem_rd,
   input logic mem_wr
);

   done_single_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
      else $error("done stayed high for more than one cycle");

   stall_during_done: assert property (@(posedge clk) disable iff (reset) done |-> stall)
      else $error("stall low while done is high");

   err_only_with_done: assert property (@(posedge clk) disable iff (reset) err |-> done)
      else $error("err raised without done");

   // Memory takes one strobe per cycle
   mem_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(mem_rd && mem_wr))
      else $error("mem_rd and mem_wr high together");

endmodule

bind mem_system mem_system_assertions protocol_checks (
   .clk    (clk),
   .reset  (reset),
   .done   (done),
   .stall  (stall),
   .err    (err),
   .mem_rd (mem_rd),
   .mem_wr (mem_wr)
);

`default_nettype wire

//--- verilog/mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system (
   input  logic                  clk,
   input  logic                  reset,
   input  mem_system_pkg::addr_t addr,
   input  mem_system_pkg::word_t data_in,
   input  logic                  rd,
   input  logic                  wr,
   output mem_system_pkg::word_t data_out,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err
);

   import mem_system_pkg::*;

   index_t                cache_index;
   logic [SEL_W-1:0]      cache_sel;
   tag_t                  cache_tag;
   word_t                 cache_wdata;
   logic                  cache_write;
   logic                  cache_mark_dirty;
   logic                  cache_fill_tag;
   word_t                 cache_rdata;
   logic                  line_hit;
   logic                  line_dirty;
   tag_t                  victim_tag;
   logic [MEM_ADDR_W-1:0] mem_addr;
   word_t                 mem_wdata;
   logic                  mem_rd;
   logic                  mem_wr;
   word_t                 mem_rdata;
   logic                  mem_rvalid;
   logic [BANKS-1:0]      mem_busy;
   logic                  mem_err;
   logic                  ctrl_err;
   word_t                 result;
   logic                  result_valid;
   word_t                 result_q;

   cache c0 (
      .clk        (clk),
      .reset      (reset),
      .index      (cache_index),
      .sel        (cache_sel),
      .tag        (cache_tag),
      .wdata      (cache_wdata),
      .write      (cache_write),
      .mark_dirty (cache_mark_dirty),
      .fill_tag   (cache_fill_tag),
      .rdata      (cache_rdata),
      .hit        (line_hit),
      .dirty      (line_dirty),
      .victim_tag (victim_tag)
   );

   four_bank_mem mem (
      .clk    (clk),
      .reset  (reset),
      .addr   (mem_addr),
      .wdata  (mem_wdata),
      .rd     (mem_rd),
      .wr     (mem_wr),
      .rdata  (mem_rdata),
      .rvalid (mem_rvalid),
      .busy   (mem_busy),
      .err    (mem_err)
   );

   cache_cntrl controller (
      .clk              (clk),
      .reset            (reset),
      .addr             (addr),
      .data_in          (data_in),
      .rd               (rd),
      .wr               (wr),
      .cache_index      (cache_index),
      .cache_sel        (cache_sel),
      .cache_tag        (cache_tag),
      .cache_wdata      (cache_wdata),
      .cache_write      (cache_write),
      .cache_mark_dirty (cache_mark_dirty),
      .cache_fill_tag   (cache_fill_tag),
      .cache_rdata      (cache_rdata),
      .line_hit         (line_hit),
      .line_dirty       (line_dirty),
      .victim_tag       (victim_tag),
      .mem_addr         (mem_addr),
      .mem_wdata        (mem_wdata),
      .mem_rd           (mem_rd),
      .mem_wr           (mem_wr),
      .mem_rdata        (mem_rdata),
      .mem_rvalid       (mem_rvalid),
      .mem_busy         (mem_busy),
      .done             (done),
      .stall            (stall),
      .cache_hit        (cache_hit),
      .err              (ctrl_err),
      .result           (result),
      .result_valid     (result_valid)
   );

   assign err = ctrl_err | mem_err;

   // Last read word held across writes
   always_ff @(posedge clk) begin
      if (result_valid) begin
         result_q <= result;
      end
   end

   assign data_out = result_valid ? result : result_q;

endmodule

`default_nettype wire

//--- verilog/cache_cntrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_cntrl (
   input  logic                                  clk,
   input  logic                                  reset,
   input  mem_system_pkg::addr_t                 addr,
   input  mem_system_pkg::word_t                 data_in,
   input  logic                                  rd,
   input  logic                                  wr,
   output mem_system_pkg::index_t                cache_index,
   output logic [mem_system_pkg::SEL_W-1:0]      cache_sel,
   output mem_system_pkg::tag_t                  cache_tag,
   output mem_system_pkg::word_t                 cache_wdata,
   output logic                                  cache_write,
   output logic                                  cache_mark_dirty,
   output logic                                  cache_fill_tag,
   input  mem_system_pkg::word_t                 cache_rdata,
   input  logic                                  line_hit,
   input  logic                                  line_dirty,
   input  mem_system_pkg::tag_t                  victim_tag,
   output logic [mem_system_pkg::MEM_ADDR_W-1:0] mem_addr,
   output mem_system_pkg::word_t                 mem_wdata,
   output logic                                  mem_rd,
   output logic                                  mem_wr,
   input  mem_system_pkg::word_t                 mem_rdata,
   input  logic                                  mem_rvalid,
   input  logic [mem_system_pkg::BANKS-1:0]      mem_busy,
   output logic                                  done,
   output logic                                  stall,
   output logic                                  cache_hit,
   output logic                                  err,
   output mem_system_pkg::word_t                 result,
   output logic                                  result_valid
);

   import mem_system_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_writeback,
      st_wait_bank,
      st_fill,
      st_finish
   } state_t;

   state_t           state;
   state_t           state_nxt;
   addr_t            req_addr;
   word_t            req_data;
   logic             req_rd;
   logic             req_bad;
   tag_t             req_tag;
   index_t           req_index;
   logic [SEL_W-1:0] req_sel;
   logic [SEL_W:0]   issue_cnt;
   logic [SEL_W-1:0] rcv_cnt;
   logic             accept;
   logic             bank_free;
   logic             last_word;

   assign req_tag = req_addr[ADDR_W-1 -: TAG_W];
   assign req_index = req_addr[SEL_W+1 +: INDEX_W];
   assign req_sel = req_addr[1 +: SEL_W];

   assign accept = (state == st_idle) && (rd || wr);
   // Word n of a line always lives in bank n
   assign bank_free = ~mem_busy[issue_cnt[SEL_W-1:0]];
   assign last_word = mem_rvalid && (rcv_cnt == '1);

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_rd <= rd;
         req_bad <= addr[0] | (rd & wr);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
         issue_cnt <= '0;
         rcv_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (state == st_lookup || state == st_wait_bank) begin
            issue_cnt <= '0;
            rcv_cnt <= '0;
         end else begin
            if (mem_rd || mem_wr) begin
               issue_cnt <= issue_cnt + 1'b1;
            end
            if (state == st_fill && mem_rvalid) begin
               rcv_cnt <= rcv_cnt + 1'b1;
            end
         end
      end
   end

   always_comb begin
      state_nxt = state;
      done = 1'b0;
      cache_hit = 1'b0;
      err = 1'b0;
      cache_write = 1'b0;
      cache_mark_dirty = 1'b0;
      cache_fill_tag = 1'b0;
      cache_sel = req_sel;
      cache_wdata = req_data;
      mem_addr = {req_tag, req_index, issue_cnt[SEL_W-1:0]};
      mem_rd = 1'b0;
      mem_wr = 1'b0;
      result_valid = 1'b0;
      case (state)
         st_idle: begin
            if (accept) begin
               state_nxt = st_lookup;
            end
         end
         st_lookup: begin
            if (req_bad) begin
               done = 1'b1;
               err = 1'b1;
               state_nxt = st_idle;
            end else if (line_hit) begin
               done = 1'b1;
               cache_hit = 1'b1;
               cache_write = ~req_rd;
               cache_mark_dirty = ~req_rd;
               result_valid = req_rd;
               state_nxt = st_idle;
            end else if (line_dirty) begin
               state_nxt = st_writeback;
            end else begin
               state_nxt = st_fill;
            end
         end
         st_writeback: begin
            // Victim goes back under its own tag
            cache_sel = issue_cnt[SEL_W-1:0];
            mem_addr = {victim_tag, req_index, issue_cnt[SEL_W-1:0]};
            mem_wr = bank_free;
            if (bank_free && issue_cnt[SEL_W-1:0] == '1) begin
               state_nxt = st_wait_bank;
            end
         end
         st_wait_bank: begin
            if (!mem_busy[0]) begin
               state_nxt = st_fill;
            end
         end
         st_fill: begin
            mem_rd = bank_free && !issue_cnt[SEL_W];
            cache_sel = rcv_cnt;
            cache_wdata = mem_rdata;
            cache_write = mem_rvalid;
            if (last_word) begin
               cache_fill_tag = 1'b1;
               state_nxt = st_finish;
            end
         end
         st_finish: begin
            done = 1'b1;
            cache_write = ~req_rd;
            cache_mark_dirty = ~req_rd;
            result_valid = req_rd;
            state_nxt = st_idle;
         end
         default: state_nxt = st_idle;
      endcase
   end

   assign stall = (state != st_idle);
   assign cache_index = req_index;
   assign cache_tag = req_tag;
   assign mem_wdata = cache_rdata;
   assign result = cache_rdata;

endmodule

`default_nettype wire

//--- verilog/four_bank_mem.sv
`timescale 1ns/1ps
`default_nettype none

module four_bank_mem (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [mem_system_pkg::MEM_ADDR_W-1:0] addr,
   input  mem_system_pkg::word_t                 wdata,
   input  logic                                  rd,
   input  logic                                  wr,
   output mem_system_pkg::word_t                 rdata,
   output logic                                  rvalid,
   output logic [mem_system_pkg::BANKS-1:0]      busy,
   output logic                                  err
);

   import mem_system_pkg::*;

   word_t                  mem [MEM_WORDS];
   word_t                  data_pipe [MEM_LATENCY];
   logic [MEM_LATENCY-1:0] valid_pipe;
   logic [BANK_W-1:0]      bank;
   logic                   strobe;
   logic                   granted;

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   // Low word address bits interleave the banks
   assign bank = addr[BANK_W-1:0];
   assign strobe = rd | wr;
   assign granted = strobe & ~busy[bank];
   assign err = strobe & busy[bank];

   for (genvar b = 0; b < BANKS; b++) begin : g_bank
      busy_cnt_t count;

      always_ff @(posedge clk) begin
         if (reset) begin
            count <= '0;
         end else if (granted && (bank == BANK_W'(b))) begin
            count <= busy_cnt_t'(BANK_BUSY);
         end else if (count != '0) begin
            count <= count - 1'b1;
         end
      end

      assign busy[b] = (count != '0);
   end

   always_ff @(posedge clk) begin
      if (wr && granted) begin
         mem[addr] <= wdata;
      end
   end

   // Read pipeline with several reads in flight
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe <= {valid_pipe[MEM_LATENCY-2:0], rd & granted};
      end
   end

   always_ff @(posedge clk) begin
      data_pipe[0] <= mem[addr];
      for (int s = 1; s < MEM_LATENCY; s++) begin
         data_pipe[s] <= data_pipe[s-1];
      end
   end

   assign rvalid = valid_pipe[MEM_LATENCY-1];
   assign rdata = data_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache (
   input  logic                             clk,
   input  logic                             reset,
   input  mem_system_pkg::index_t           index,
   input  logic [mem_system_pkg::SEL_W-1:0] sel,
   input  mem_system_pkg::tag_t             tag,
   input  mem_system_pkg::word_t            wdata,
   input  logic                             write,
   input  logic                             mark_dirty,
   input  logic                             fill_tag,
   output mem_system_pkg::word_t            rdata,
   output logic                             hit,
   output logic                             dirty,
   output mem_system_pkg::tag_t             victim_tag
);

   import mem_system_pkg::*;

   tag_entry_t entry_rd;
   tag_entry_t entry_wr;
   logic       tag_we;

   // Tag entry rewritten on a fill or on a write that dirties the line
   assign tag_we = fill_tag | (write & mark_dirty);
   assign entry_wr = '{valid: 1'b1, dirty: mark_dirty, tag: tag};

   cache_array #(
      .entry_t        (tag_entry_t),
      .depth          (LINES),
      .clear_on_reset (1'b1)
   ) tag_store (
      .clk    (clk),
      .reset  (reset),
      .waddr  (index),
      .we     (tag_we),
      .wentry (entry_wr),
      .raddr  (index),
      .rentry (entry_rd)
   );

   cache_array #(
      .entry_t        (word_t),
      .depth          (LINES * WORDS_PER_LINE),
      .clear_on_reset (1'b0)
   ) data_store (
      .clk    (clk),
      .reset  (reset),
      .waddr  ({index, sel}),
      .we     (write),
      .wentry (wdata),
      .raddr  ({index, sel}),
      .rentry (rdata)
   );

   assign hit = entry_rd.valid && (entry_rd.tag == tag);
   // Describes the resident line whether it hits or not
   assign dirty = entry_rd.valid && entry_rd.dirty;
   assign victim_tag = entry_rd.tag;

endmodule

`default_nettype wire

//--- verilog/cache_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
   parameter type entry_t = logic,
   parameter int depth = 16,
   parameter bit clear_on_reset = 1'b0
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [$clog2(depth)-1:0] waddr,
   input  logic                     we,
   input  entry_t                   wentry,
   input  logic [$clog2(depth)-1:0] raddr,
   output entry_t                   rentry
);

   entry_t store [depth];

   always_ff @(posedge clk) begin
      if (clear_on_reset && reset) begin
         for (int i = 0; i < depth; i++) begin
            store[i] <= '0;
         end
      end else if (we) begin
         store[waddr] <= wentry;
      end
   end

   // Read is combinational
   assign rentry = store[raddr];

endmodule

`default_nettype wire

//--- verilog/mem_system_pkg.sv
`default_nettype none

package mem_system_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;
   localparam int TAG_W = 5;
   localparam int INDEX_W = 8;
   localparam int SEL_W = 2;
   localparam int LINES = 256;
   localparam int WORDS_PER_LINE = 4;

   // Word-addressed backing store
   localparam int MEM_WORDS = 32768;
   localparam int MEM_ADDR_W = $clog2(MEM_WORDS);
   localparam int MEM_LATENCY = 2;
   localparam int BANK_BUSY = 4;
   localparam int BANKS = 4;
   localparam int BANK_W = $clog2(BANKS);
   localparam int BUSY_CNT_W = $clog2(BANK_BUSY + 1);

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [BUSY_CNT_W-1:0] busy_cnt_t;

   typedef struct packed {
      logic valid;
      logic dirty;
      tag_t tag;
   } tag_entry_t;

endpackage

`default_nettype wire
